// File: board_pkg.sv
package board_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Boot straps
  ////////////////////////////////////////////////////////////////////////////

  // Boot source as seen by the SoC boot ROM
  typedef enum logic [1:0] {
    BootPassive = 2'd0,
    BootSdCard  = 2'd1,
    BootSpiNor  = 2'd2,
    BootUart    = 2'd3
  } boot_mode_t;

  ////////////////////////////////////////////////////////////////////////////
  // Pad bundles
  ////////////////////////////////////////////////////////////////////////////

  // SPI host outputs as they leave the SoC
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd_out;
    // Output enable of data line 0 only
    logic       sd_en_lo;
  } spi_soc_t;

  // microSD pins driven by the FPGA in SPI mode
  typedef struct packed {
    logic       sclk;
    logic       cmd;
    logic       dat3;
    logic [1:0] dat2_1;
  } sd_pads_t;

  ////////////////////////////////////////////////////////////////////////////
  // Default timing
  ////////////////////////////////////////////////////////////////////////////

  // RTC half period minus one, 50 MHz down to 1 MHz
  localparam int unsigned RtcDivHalfDefault = 24;
  // soc_clk cycles per PWM step
  localparam int unsigned FanPrescaleDefault = 4;

endpackage

// File: reset_ctrl.sv
`timescale 1ns/1ns

module reset_ctrl (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  test_mode_i,
  input  board_pkg::boot_mode_t boot_sw_i,
  input  board_pkg::boot_mode_t boot_ovr_i,
  input  logic                  boot_ovr_sel_i,
  output logic                  soc_rst_no,
  output board_pkg::boot_mode_t boot_mode_o
);

  logic [1:0]            sync_q;
  logic                  release_edge;
  board_pkg::boot_mode_t boot_sel;
  board_pkg::boot_mode_t boot_mode_q;

  ////////////////////////////////////////////////////////////////////////////
  // Reset synchronizer
  ////////////////////////////////////////////////////////////////////////////

  // Asserts with rst_n, releases two edges later
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Scan mode hands the board reset straight through
  assign soc_rst_no = test_mode_i ? rst_n : sync_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // Boot strap register
  ////////////////////////////////////////////////////////////////////////////

  // True on the edge that lifts the synchronized reset
  assign release_edge = (sync_q == 2'b01);

  // Debug probe wins over the board switches
  assign boot_sel = boot_ovr_sel_i ? boot_ovr_i : boot_sw_i;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_mode_q <= board_pkg::BootPassive;
    end else if (release_edge) begin
      boot_mode_q <= boot_sel;
    end
  end

  assign boot_mode_o = boot_mode_q;

endmodule

// File: rtc_divider.sv
`timescale 1ns/1ns

module rtc_divider #(
  parameter int unsigned RtcDivHalf = board_pkg::RtcDivHalfDefault
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  // Counter just wide enough to reach RtcDivHalf
  localparam int unsigned CntW = (RtcDivHalf > 0) ? $clog2(RtcDivHalf + 1) : 1;

  logic [CntW-1:0] cnt_q;
  logic            cnt_wrap;
  logic            rtc_q;

  assign cnt_wrap = (cnt_q == CntW'(RtcDivHalf));

  // One toggle per RtcDivHalf+1 cycles
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_wrap) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

endmodule

// File: fan_pwm_ctrl.sv
`timescale 1ns/1ns

module fan_pwm_ctrl #(
  parameter int unsigned FanPrescale = board_pkg::FanPrescaleDefault
) (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic [3:0] fan_sw_i,
  output logic       fan_pwm_o
);

  localparam int unsigned PscW = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;

  logic [PscW-1:0] psc_q;
  logic            psc_wrap;
  logic [3:0]      step_q;
  logic            period_end;
  logic [3:0]      setting_q;

  ////////////////////////////////////////////////////////////////////////////
  // Prescaler and step counter
  ////////////////////////////////////////////////////////////////////////////

  assign psc_wrap   = (psc_q == PscW'(FanPrescale - 1));
  assign period_end = psc_wrap && (step_q == 4'hf);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      psc_q  <= '0;
      step_q <= '0;
    end else if (psc_wrap) begin
      psc_q  <= '0;
      // 16 steps, wraps on its own
      step_q <= step_q + 1'b1;
    end else begin
      psc_q <= psc_q + 1'b1;
    end
  end

  // Setting only changes when step 0 begins
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      setting_q <= '0;
    end else if (period_end) begin
      setting_q <= fan_sw_i;
    end
  end

  // Setting 15 still leaves the last step low
  assign fan_pwm_o = (step_q < setting_q);

endmodule

// File: sd_spi_adapter.sv
`timescale 1ns/1ns

module sd_spi_adapter (
  input  board_pkg::spi_soc_t spi_i,
  input  logic                sd_dat0_i,
  output board_pkg::sd_pads_t sd_o,
  output logic                spi_miso_o
);

  ////////////////////////////////////////////////////////////////////////////
  // SPI host to microSD in SPI mode
  ////////////////////////////////////////////////////////////////////////////

  // Lines without an enable idle high, as the card expects
  always_comb begin
    sd_o = '1;

    // SCK to card clock
    if (spi_i.sck_en) begin
      sd_o.sclk = spi_i.sck;
    end

    // Chip select 0 to DAT3
    if (spi_i.csb_en[0]) begin
      sd_o.dat3 = spi_i.csb[0];
    end

    // MOSI to CMD
    if (spi_i.sd_en_lo) begin
      sd_o.cmd = spi_i.sd_out[0];
    end

    // DAT1 and DAT2 are unused in SPI mode
    sd_o.dat2_1 = 2'b11;
  end

  // Card DAT0 carries MISO back to the host
  assign spi_miso_o = sd_dat0_i;

endmodule

// File: board_glue_top.sv
`timescale 1ns/1ns

module board_glue_top #(
  parameter int unsigned RtcDivHalf  = board_pkg::RtcDivHalfDefault,
  parameter int unsigned FanPrescale = board_pkg::FanPrescaleDefault
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  test_mode_i,
  input  board_pkg::boot_mode_t boot_sw_i,
  input  board_pkg::boot_mode_t boot_ovr_i,
  input  logic                  boot_ovr_sel_i,
  input  logic [3:0]            fan_sw_i,
  input  board_pkg::spi_soc_t   spi_i,
  input  logic                  sd_dat0_i,
  output logic                  soc_rst_no,
  output board_pkg::boot_mode_t boot_mode_o,
  output logic                  rtc_o,
  output logic                  fan_pwm_o,
  output board_pkg::sd_pads_t   sd_o,
  output logic                  sd_reset_o,
  output logic                  spi_miso_o
);

  // Reset and straps, feeds everything clocked below
  reset_ctrl i_reset_ctrl (
    .soc_clk        ( soc_clk        ),
    .rst_n          ( rst_n          ),
    .test_mode_i    ( test_mode_i    ),
    .boot_sw_i      ( boot_sw_i      ),
    .boot_ovr_i     ( boot_ovr_i     ),
    .boot_ovr_sel_i ( boot_ovr_sel_i ),
    .soc_rst_no     ( soc_rst_no     ),
    .boot_mode_o    ( boot_mode_o    )
  );

  rtc_divider #(
    .RtcDivHalf ( RtcDivHalf )
  ) i_rtc_divider (
    .soc_clk ( soc_clk    ),
    .rst_n   ( soc_rst_no ),
    .rtc_o   ( rtc_o      )
  );

  fan_pwm_ctrl #(
    .FanPrescale ( FanPrescale )
  ) i_fan_pwm_ctrl (
    .soc_clk   ( soc_clk    ),
    .rst_n     ( soc_rst_no ),
    .fan_sw_i  ( fan_sw_i   ),
    .fan_pwm_o ( fan_pwm_o  )
  );

  sd_spi_adapter i_sd_spi_adapter (
    .spi_i      ( spi_i      ),
    .sd_dat0_i  ( sd_dat0_i  ),
    .sd_o       ( sd_o       ),
    .spi_miso_o ( spi_miso_o )
  );

  // Card reset held low keeps the card powered
  assign sd_reset_o = 1'b0;

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 10,
  parameter int unsigned ResetCycles = 10
) (
  output logic soc_clk,
  output logic rst_no
);

  initial begin
    soc_clk = 1'b0;
    forever #HalfPeriod soc_clk = ~soc_clk;
  end

  // Power-on reset, lifted just after the last counted edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge soc_clk);
    #2;
    rst_no = 1'b1;
  end

endmodule

// File: tb_board_glue.sv
`timescale 1ns/1ns

module tb_board_glue;

  localparam int unsigned RtcDivHalf  = board_pkg::RtcDivHalfDefault;
  localparam int unsigned FanPrescale = board_pkg::FanPrescaleDefault;
  localparam int unsigned PwmPeriod   = 16 * FanPrescale;

  logic                  soc_clk;
  logic                  por_rst_n;
  logic                  cmd_rst_n;
  logic                  rst_n;
  logic                  test_mode_i;
  board_pkg::boot_mode_t boot_sw_i;
  board_pkg::boot_mode_t boot_ovr_i;
  logic                  boot_ovr_sel_i;
  logic [3:0]            fan_sw_i;
  board_pkg::spi_soc_t   spi_i;
  logic                  sd_dat0_i;
  logic                  soc_rst_no;
  board_pkg::boot_mode_t boot_mode_o;
  logic                  rtc_o;
  logic                  fan_pwm_o;
  board_pkg::sd_pads_t   sd_o;
  logic                  sd_reset_o;
  logic                  spi_miso_o;

  integer seed = 32'hfb03_ea67;
  int     errors = 0;
  int     checks = 0;
  int     cycle_cnt = 0;
  int     limit_cycles = 0;

  // Board reset is the power-on reset combined with commanded resets
  assign rst_n = por_rst_n & cmd_rst_n;

  tb_clk_gen i_clk_gen (
    .soc_clk ( soc_clk   ),
    .rst_no  ( por_rst_n )
  );

  board_glue_top #(
    .RtcDivHalf  ( RtcDivHalf  ),
    .FanPrescale ( FanPrescale )
  ) dut_i (
    .soc_clk        ( soc_clk        ),
    .rst_n          ( rst_n          ),
    .test_mode_i    ( test_mode_i    ),
    .boot_sw_i      ( boot_sw_i      ),
    .boot_ovr_i     ( boot_ovr_i     ),
    .boot_ovr_sel_i ( boot_ovr_sel_i ),
    .fan_sw_i       ( fan_sw_i       ),
    .spi_i          ( spi_i          ),
    .sd_dat0_i      ( sd_dat0_i      ),
    .soc_rst_no     ( soc_rst_no     ),
    .boot_mode_o    ( boot_mode_o    ),
    .rtc_o          ( rtc_o          ),
    .fan_pwm_o      ( fan_pwm_o      ),
    .sd_o           ( sd_o           ),
    .sd_reset_o     ( sd_reset_o     ),
    .spi_miso_o     ( spi_miso_o     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge soc_clk) begin
    cycle_cnt++;
    if (limit_cycles != 0 && cycle_cnt > limit_cycles) begin
      $display("Run stopped: cycle limit of %0d reached", limit_cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Operand count of a command line
  function automatic bit fields_ok(input string line, input int got, input int want);
    if (got != want) begin
      $display("Malformed line in input file: %s", line);
      errors++;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // Inputs change 2 ns after the edge, outputs are sampled there too
  task automatic wait_cycle();
    @(posedge soc_clk);
    #2;
  endtask

  // Idle-high pins unless the matching enable is set
  function automatic board_pkg::sd_pads_t expected_pads(board_pkg::spi_soc_t spi);
    board_pkg::sd_pads_t p;
    p.sclk   = spi.sck_en ? spi.sck : 1'b1;
    p.cmd    = spi.sd_en_lo ? spi.sd_out[0] : 1'b1;
    p.dat3   = spi.csb_en[0] ? spi.csb[0] : 1'b1;
    p.dat2_1 = 2'b11;
    return p;
  endfunction

  task automatic run_reset(input logic [1:0] sw, input logic [1:0] ovr,
                           input logic sel, input logic [1:0] exp);
    boot_sw_i      = board_pkg::boot_mode_t'(sw);
    boot_ovr_i     = board_pkg::boot_mode_t'(ovr);
    boot_ovr_sel_i = sel;
    cmd_rst_n      = 1'b0;
    #1;
    check_val("soc_rst_no", soc_rst_no, 1'b0);
    check_val("boot_mode_o", boot_mode_o, 2'd0);
    repeat (3) wait_cycle();
    cmd_rst_n = 1'b1;
    wait_cycle();
    check_val("soc_rst_no", soc_rst_no, 1'b0);
    wait_cycle();
    check_val("soc_rst_no", soc_rst_no, 1'b1);
    check_val("boot_mode_o", boot_mode_o, exp);
    // Straps must not follow the switches after release
    boot_sw_i      = board_pkg::boot_mode_t'(~sw);
    boot_ovr_i     = board_pkg::boot_mode_t'(~ovr);
    boot_ovr_sel_i = ~sel;
    repeat (2) wait_cycle();
    check_val("boot_mode_o", boot_mode_o, exp);
  endtask

  task automatic run_test_mode();
    test_mode_i = 1'b1;
    cmd_rst_n   = 1'b0;
    #1;
    check_val("soc_rst_no", soc_rst_no, 1'b0);
    cmd_rst_n = 1'b1;
    #1;
    check_val("soc_rst_no", soc_rst_no, 1'b1);
    test_mode_i = 1'b0;
    while (soc_rst_no !== 1'b1) begin
      wait_cycle();
    end
  endtask

  task automatic run_rtc(input int exp_half);
    logic prev;
    int   cnt;
    prev = rtc_o;
    while (rtc_o === prev) begin
      wait_cycle();
    end
    prev = rtc_o;
    cnt  = 0;
    while (rtc_o === prev) begin
      wait_cycle();
      cnt++;
    end
    check_val("rtc_o half period", cnt, exp_half);
  endtask

  task automatic run_fan(input logic [3:0] setting, input int exp_high);
    int high;
    fan_sw_i = setting;
    // One full period lets the new setting reach step 0
    repeat (PwmPeriod) wait_cycle();
    high = 0;
    repeat (PwmPeriod) begin
      wait_cycle();
      if (fan_pwm_o === 1'b1) begin
        high++;
      end
    end
    check_val("fan_pwm_o high cycles", high, exp_high);
  endtask

  task automatic apply_pads(input board_pkg::spi_soc_t spi, input logic dat0,
                            input logic [4:0] exp_sd, input logic exp_miso);
    spi_i     = spi;
    sd_dat0_i = dat0;
    #1;
    check_val("sd_o", sd_o, exp_sd);
    check_val("spi_miso_o", spi_miso_o, exp_miso);
    check_val("sd_reset_o", sd_reset_o, 1'b0);
    wait_cycle();
  endtask

  task automatic run_random(input int count);
    logic [31:0]         r;
    board_pkg::spi_soc_t spi;
    repeat (count) begin
      r   = $random(seed);
      spi = r[10:0];
      apply_pads(spi, r[11], expected_pads(spi), r[11]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Command file
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    integer      fd;
    int          n;
    int          lines;
    string       line;
    byte         cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;

    cmd_rst_n      = 1'b1;
    test_mode_i    = 1'b0;
    boot_sw_i      = board_pkg::BootPassive;
    boot_ovr_i     = board_pkg::BootPassive;
    boot_ovr_sel_i = 1'b0;
    fan_sw_i       = 4'h0;
    spi_i          = '0;
    sd_dat0_i      = 1'b0;

    // First pass sizes the watchdog
    lines = 0;
    fd = $fopen("board_glue_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open board_glue_input.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          lines++;
        end
      end
      $fclose(fd);
    end
    limit_cycles = lines * 200 + 1000;

    @(posedge por_rst_n);
    while (soc_rst_no !== 1'b1) begin
      wait_cycle();
    end

    fd = $fopen("board_glue_input.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          cmd = line[0];
          case (cmd)
            "R": begin
              n = $sscanf(line, "R %h %h %h %h", a, b, c, d);
              if (fields_ok(line, n, 4)) begin
                run_reset(a[1:0], b[1:0], c[0], d[1:0]);
              end
            end
            "T": run_test_mode();
            "P": begin
              n = $sscanf(line, "P %d", a);
              if (fields_ok(line, n, 1)) begin
                run_rtc(a);
              end
            end
            "F": begin
              n = $sscanf(line, "F %h %d", a, b);
              if (fields_ok(line, n, 2)) begin
                run_fan(a[3:0], b);
              end
            end
            "S": begin
              n = $sscanf(line, "S %h %h %h %h", a, b, c, d);
              if (fields_ok(line, n, 4)) begin
                apply_pads(a[10:0], b[0], c[4:0], d[0]);
              end
            end
            "N": begin
              n = $sscanf(line, "N %d", a);
              if (fields_ok(line, n, 1)) begin
                run_random(a);
              end
            end
            default: begin
              $display("Unknown command in input file: %s", line);
              errors++;
            end
          endcase
        end
      end
      $fclose(fd);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: board_glue_input.txt
# R sw ovr sel exp_boot | T | P exp_half_cycles | F setting(hex) exp_high_cycles
# S spi(hex) dat0 exp_sd(hex) exp_miso | N random_bundle_count
R 1 3 0 1
R 1 3 1 3
R 2 0 0 2
R 0 2 1 2
R 3 1 1 1
T
R 0 0 0 0
P 25
P 25
F 0 0
F 1 4
F 8 32
F f 60
F 0 0
S 000 0 1f 0
S 7ff 1 1f 1
S 261 1 03 1
S 722 0 1b 0
S 1dd 1 17 1
S 200 0 0f 0
N 24
R 2 1 0 2
T
P 25
F 8 32

// File: tb.f
board_pkg.sv
reset_ctrl.sv
rtc_divider.sv
fan_pwm_ctrl.sv
sd_spi_adapter.sv
board_glue_top.sv
tb_clk_gen.sv
tb_board_glue.sv
